//--- src/x86_opnd_pkg.sv
`default_nettype none

package x86_opnd_pkg;

  // Unescaped instruction window, byte 0 is the first byte after the opcode
  typedef logic [87:0] instr_window_t;

  // Operand-form code from the opcode tables
  typedef logic [3:0] opnd_form_t;

  // ModR/M and SIB bytes
  typedef logic [7:0] byte_t;

  // Displacement or immediate after extension
  typedef logic [31:0] word32_t;

  // Byte count of one field, 0, 1, 2 or 4
  typedef logic [2:0] field_len_t;

  // Displacement plus immediate bytes, at most 8
  typedef logic [3:0] total_len_t;

  // Operand forms, codes 14 and 15 behave as FORM_NONE
  localparam opnd_form_t FORM_NONE       = 4'd0;
  localparam opnd_form_t FORM_IMM        = 4'd1;
  localparam opnd_form_t FORM_REG_IMM    = 4'd2;
  localparam opnd_form_t FORM_EAX_IMM    = 4'd3;
  localparam opnd_form_t FORM_RM         = 4'd4;
  localparam opnd_form_t FORM_RM_IMM     = 4'd5;
  localparam opnd_form_t FORM_RM_REG     = 4'd6;
  localparam opnd_form_t FORM_RM_REG_IMM = 4'd7;
  localparam opnd_form_t FORM_RM_REG_CL  = 4'd8;
  localparam opnd_form_t FORM_RM_CL      = 4'd9;
  localparam opnd_form_t FORM_REG_RM     = 4'd10;
  localparam opnd_form_t FORM_REG_RM_IMM = 4'd11;
  localparam opnd_form_t FORM_DISP8      = 4'd12;
  localparam opnd_form_t FORM_DISP32     = 4'd13;

  // Addressing result
  typedef struct packed {
    logic    has_modrm;
    logic    has_sib;
    logic    has_disp;
    logic    is_disp8;
    logic    is_disp32;
    logic    rm_reg_direct;
    byte_t   modrm;
    byte_t   sib;
    word32_t disp;
    // Operand routing of the ModR/M fields and the displacement
    logic    opnd0_rm;
    logic    opnd0_reg;
    logic    opnd1_rm;
    logic    opnd1_reg;
    logic    opnd0_disp;
    logic    opnd1_disp;
  } addr_info_t;

  // Immediate classification, no data yet
  typedef struct packed {
    logic       has_imm;
    field_len_t imm_len;
    logic       imm_sext;
  } imm_info_t;

  // Registered decoder output
  typedef struct packed {
    addr_info_t addr;
    logic       has_imm;
    word32_t    imm;
    total_len_t imm_disp_len;
  } opnd_sig_t;

  // Four window bytes starting at byte offset off, upper bytes past the window read 0
  function automatic word32_t window_word(instr_window_t w, logic [2:0] off);
    return word32_t'(w >> {off, 3'b000});
  endfunction

  // Keep len bytes of raw, 8-bit fields may sign-extend
  function automatic word32_t extend_field(word32_t raw, field_len_t len, logic sext);
    word32_t res;
    case (len)
      3'd1:    res = {{24{sext & raw[7]}}, raw[7:0]};
      // 16-bit fields are always zero-extended
      3'd2:    res = {16'h0000, raw[15:0]};
      3'd4:    res = raw;
      default: res = '0;
    endcase
    return res;
  endfunction

  // Displacement byte count from the size flags
  function automatic field_len_t disp_len_of(logic is_disp8, logic is_disp32);
    return is_disp32 ? 3'd4 : (is_disp8 ? 3'd1 : 3'd0);
  endfunction

endpackage

`default_nettype wire

//--- src/modrm_sib_decode.sv
`timescale 1ns/1ns
`default_nettype none

module modrm_sib_decode import x86_opnd_pkg::*; (
  input  wire instr_window_t instr,
  input  wire opnd_form_t    form,
  input  wire logic          addr16,
  input  wire logic          source_is_sext,
  output addr_info_t         addr
);

  logic       opnd0_rm;
  logic       opnd0_reg;
  logic       opnd1_reg;
  logic       has_modrm;
  byte_t      modrm_byte;
  logic [1:0] mod;
  logic [2:0] rm;
  logic       rm_direct;
  logic       has_sib;
  byte_t      sib_byte;
  logic       modrm_disp;
  logic       sib_disp;
  logic       form_disp8;
  logic       form_disp32;
  logic       has_disp;
  logic       is_disp8;
  logic       is_disp32;
  logic       disp_sext;
  logic [2:0] disp_off;
  field_len_t disp_len;
  word32_t    disp;

  // R/M field is operand 0, direction bit clear
  assign opnd0_rm = form inside {FORM_RM, FORM_RM_IMM, FORM_RM_REG,
                                 FORM_RM_REG_IMM, FORM_RM_REG_CL, FORM_RM_CL};

  // REG field is operand 0, direction bit set
  assign opnd0_reg = form inside {FORM_REG_RM, FORM_REG_RM_IMM};

  // REG field as second operand
  assign opnd1_reg = form inside {FORM_RM_REG, FORM_RM_REG_IMM, FORM_RM_REG_CL};

  // Any routing class implies a ModR/M byte
  assign has_modrm = opnd0_rm | opnd0_reg;

  // ModR/M sits at byte 0, reported as 0 when absent
  assign modrm_byte = has_modrm ? instr[7:0] : '0;
  assign mod        = modrm_byte[7:6];
  assign rm         = modrm_byte[2:0];

  // mod 3 selects a register instead of memory
  assign rm_direct = has_modrm & (mod == 2'b11);

  // SIB escape is rm 4 in a memory mode, not available with 16-bit addressing
  assign has_sib = has_modrm & ~addr16 & ~rm_direct & (rm == 3'd4);

  // SIB follows ModR/M at byte 1
  assign sib_byte = has_sib ? instr[15:8] : '0;

  // Memory modes with a displacement, mod 0 rm 5 is the absolute disp32 case
  assign modrm_disp = has_modrm & ~rm_direct &
                      ((mod == 2'b01) | (mod == 2'b10) | ((mod == 2'b00) & (rm == 3'd5)));

  // SIB base 5 adds a displacement (disp32 for mod 0)
  assign sib_disp = has_sib & (sib_byte[2:0] == 3'd5);

  // Displacement-only forms without a ModR/M byte
  assign form_disp8  = (form == FORM_DISP8);
  assign form_disp32 = (form == FORM_DISP32);

  assign has_disp = modrm_disp | sib_disp | form_disp8 | form_disp32;

  // Only mod 1 and the DISP8 form carry a single byte
  assign is_disp8  = has_disp & (form_disp8 | (has_modrm & (mod == 2'b01)));
  assign is_disp32 = has_disp & ~is_disp8;

  // Addressing disp8 is signed, a DISP8 form follows the opcode flag
  assign disp_sext = has_modrm | source_is_sext;

  // Displacement starts behind SIB, behind ModR/M, or at byte 0
  always_comb begin
    if (has_sib) begin
      disp_off = 3'd2;
    end else if (has_modrm) begin
      disp_off = 3'd1;
    end else begin
      disp_off = 3'd0;
    end
  end

  assign disp_len = disp_len_of(is_disp8, is_disp32);

  // Length 0 yields 0 when there is no displacement
  assign disp = extend_field(window_word(instr, disp_off), disp_len, disp_sext);

  always_comb begin
    addr.has_modrm     = has_modrm;
    addr.has_sib       = has_sib;
    addr.has_disp      = has_disp;
    addr.is_disp8      = is_disp8;
    addr.is_disp32     = is_disp32;
    addr.rm_reg_direct = rm_direct;
    addr.modrm         = modrm_byte;
    addr.sib           = sib_byte;
    addr.disp          = disp;
    addr.opnd0_rm      = opnd0_rm;
    addr.opnd0_reg     = opnd0_reg;
    // With the direction bit set, R/M moves to operand 1
    addr.opnd1_rm      = opnd0_reg;
    addr.opnd1_reg     = opnd1_reg;
    // Displacement belongs to whichever operand is addressed through R/M
    addr.opnd0_disp    = form_disp8 | form_disp32 | (has_disp & opnd0_rm);
    addr.opnd1_disp    = has_disp & opnd0_reg;
  end

endmodule

`default_nettype wire

//--- src/imm_decode.sv
`timescale 1ns/1ns
`default_nettype none

module imm_decode import x86_opnd_pkg::*; (
  input  wire opnd_form_t form,
  input  wire logic       oper16,
  input  wire logic       imm_1byte,
  input  wire logic       source_is_sext,
  output imm_info_t       imm
);

  logic       has_imm;
  logic       is_imm8;
  logic       is_imm16;
  logic       is_imm32;
  field_len_t imm_len;

  // Forms that end in an immediate
  always_comb begin
    case (form)
      FORM_IMM,
      FORM_REG_IMM,
      FORM_EAX_IMM,
      FORM_RM_IMM,
      FORM_RM_REG_IMM,
      FORM_REG_RM_IMM: has_imm = 1'b1;
      default:         has_imm = 1'b0;
    endcase
  end

  // Byte-immediate opcodes ignore the operand-size prefix
  assign is_imm8 = has_imm & imm_1byte;

  // 66h prefix shrinks a full immediate to a word
  assign is_imm16 = has_imm & ~imm_1byte & oper16;

  // Default operand size is 32 bits
  assign is_imm32 = has_imm & ~imm_1byte & ~oper16;

  always_comb begin
    if (is_imm32) begin
      imm_len = 3'd4;
    end else if (is_imm16) begin
      imm_len = 3'd2;
    end else if (is_imm8) begin
      imm_len = 3'd1;
    end else begin
      imm_len = 3'd0;
    end
  end

  always_comb begin
    imm.has_imm  = has_imm;
    imm.imm_len  = imm_len;
    // Only a byte immediate can be sign-extended
    imm.imm_sext = is_imm8 & source_is_sext;
  end

endmodule

`default_nettype wire

//--- src/opnd_assemble.sv
`timescale 1ns/1ns
`default_nettype none

module opnd_assemble import x86_opnd_pkg::*; (
  input  wire logic          clk,
  input  wire logic          arst_n,
  input  wire logic          valid,
  input  wire instr_window_t instr,
  input  wire addr_info_t    addr,
  input  wire imm_info_t     imm,
  output logic               out_valid,
  output opnd_sig_t          sig
);

  field_len_t disp_len;
  logic [2:0] imm_off;
  word32_t    imm_raw;
  word32_t    imm_val;
  total_len_t len_sum;
  opnd_sig_t  sig_d;

  assign disp_len = disp_len_of(addr.is_disp8, addr.is_disp32);

  // Immediate follows ModR/M, SIB and displacement, at most byte 6
  assign imm_off = {2'b00, addr.has_modrm} + {2'b00, addr.has_sib} + disp_len;

  // Up to four bytes from the immediate offset
  assign imm_raw = window_word(instr, imm_off);

  // imm_len of 0 forces the immediate to 0
  assign imm_val = extend_field(imm_raw, imm.imm_len, imm.imm_sext);

  // 4 + 4 at most, fits in four bits
  assign len_sum = {1'b0, disp_len} + {1'b0, imm.imm_len};

  always_comb begin
    sig_d.addr         = addr;
    sig_d.has_imm      = imm.has_imm;
    sig_d.imm          = imm_val;
    sig_d.imm_disp_len = len_sum;
  end

  // Output stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      sig       <= '0;
    end else begin
      out_valid <= valid;
      // Hold the last result between beats
      if (valid) begin
        sig <= sig_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/x86_opnd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module x86_opnd_decode import x86_opnd_pkg::*; (
  input  wire logic          clk,
  input  wire logic          arst_n,
  input  wire logic          in_valid,
  input  wire instr_window_t instr,
  input  wire opnd_form_t    form,
  input  wire logic          addr16,
  input  wire logic          oper16,
  input  wire logic          imm_1byte,
  input  wire logic          source_is_sext,
  output logic               out_valid,
  output opnd_sig_t          sig
);

  // One captured instruction with its flags
  typedef struct packed {
    instr_window_t instr;
    opnd_form_t    form;
    logic          addr16;
    logic          oper16;
    logic          imm_1byte;
    logic          source_is_sext;
  } capture_t;

  capture_t   cap_q;
  logic       valid_q;
  addr_info_t addr_info;
  imm_info_t  imm_info;

  // Input capture, loads on every strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      cap_q.instr          <= instr;
      cap_q.form           <= form;
      cap_q.addr16         <= addr16;
      cap_q.oper16         <= oper16;
      cap_q.imm_1byte      <= imm_1byte;
      cap_q.source_is_sext <= source_is_sext;
    end
  end

  // First valid stage, the second lives in opnd_assemble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  modrm_sib_decode u_modrm_sib_decode (
    .instr          (cap_q.instr),
    .form           (cap_q.form),
    .addr16         (cap_q.addr16),
    .source_is_sext (cap_q.source_is_sext),
    .addr           (addr_info)
  );

  imm_decode u_imm_decode (
    .form           (cap_q.form),
    .oper16         (cap_q.oper16),
    .imm_1byte      (cap_q.imm_1byte),
    .source_is_sext (cap_q.source_is_sext),
    .imm            (imm_info)
  );

  // Immediate extraction and output register
  opnd_assemble u_opnd_assemble (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid     (valid_q),
    .instr     (cap_q.instr),
    .addr      (addr_info),
    .imm       (imm_info),
    .out_valid (out_valid),
    .sig       (sig)
  );

endmodule

`default_nettype wire

//--- tests/x86_opnd_decode_props.sv
`timescale 1ns/1ns
`default_nettype none

module x86_opnd_decode_props import x86_opnd_pkg::*; (
  input wire logic      clk,
  input wire logic      arst_n,
  input wire logic      in_valid,
  input wire logic      out_valid,
  input wire opnd_sig_t sig
);

  int fail_count = 0;

  // No output beat while reset is held
  reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high during reset");
    end

  // Fixed two-edge latency from the input strobe
  latency_two: assert property (@(posedge clk) disable iff (!arst_n)
                                out_valid == $past(in_valid, 2))
    else begin
      fail_count++;
      $error("out_valid does not follow in_valid two edges earlier");
    end

  // SIB only exists behind a ModR/M byte
  sib_needs_modrm: assert property (@(posedge clk) disable iff (!arst_n)
                                    out_valid && sig.addr.has_sib |-> sig.addr.has_modrm)
    else begin
      fail_count++;
      $error("has_sib set without has_modrm");
    end

  // disp32 plus imm32 is the longest case
  len_bound: assert property (@(posedge clk) disable iff (!arst_n)
                              out_valid |-> sig.imm_disp_len <= 4'd8)
    else begin
      fail_count++;
      $error("imm_disp_len above 8");
    end

endmodule

`default_nettype wire

//--- tests/opnd_checker.sv
`timescale 1ns/1ns
`default_nettype none

module opnd_checker import x86_opnd_pkg::*; (
  input wire logic      clk,
  input wire logic      arst_n,
  input wire logic      out_valid,
  input wire opnd_sig_t sig
);

  // Pushed at the strobe's falling edge, seen two falling edges later
  localparam time LATENCY = 20;

  opnd_sig_t exp_q [$];
  time       due_q [$];
  int        pending = 0;
  int        mismatches = 0;
  int        other_errors = 0;

  task automatic push_expected(input opnd_sig_t e);
    exp_q.push_back(e);
    due_q.push_back($time + LATENCY);
    pending++;
  endtask

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  // Outputs change on the rising edge, so compare on the falling edge
  always @(negedge clk) begin : compare
    opnd_sig_t e;
    time       due;
    if (out_valid && arst_n) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected output beat at t=%0t with no input outstanding", $time);
        other_errors++;
      end else begin
        e = exp_q.pop_front();
        due = due_q.pop_front();
        pending--;
        if (due != $time) begin
          $display("Output beat at t=%0t arrived off schedule, due at t=%0t", $time, due);
          other_errors++;
        end
        check_field("has_modrm", e.addr.has_modrm, sig.addr.has_modrm);
        check_field("has_sib", e.addr.has_sib, sig.addr.has_sib);
        check_field("has_disp", e.addr.has_disp, sig.addr.has_disp);
        check_field("is_disp8", e.addr.is_disp8, sig.addr.is_disp8);
        check_field("is_disp32", e.addr.is_disp32, sig.addr.is_disp32);
        check_field("rm_reg_direct", e.addr.rm_reg_direct, sig.addr.rm_reg_direct);
        check_field("modrm", e.addr.modrm, sig.addr.modrm);
        check_field("sib", e.addr.sib, sig.addr.sib);
        check_field("disp", e.addr.disp, sig.addr.disp);
        check_field("opnd0_rm", e.addr.opnd0_rm, sig.addr.opnd0_rm);
        check_field("opnd0_reg", e.addr.opnd0_reg, sig.addr.opnd0_reg);
        check_field("opnd1_rm", e.addr.opnd1_rm, sig.addr.opnd1_rm);
        check_field("opnd1_reg", e.addr.opnd1_reg, sig.addr.opnd1_reg);
        check_field("opnd0_disp", e.addr.opnd0_disp, sig.addr.opnd0_disp);
        check_field("opnd1_disp", e.addr.opnd1_disp, sig.addr.opnd1_disp);
        check_field("has_imm", e.has_imm, sig.has_imm);
        check_field("imm", e.imm, sig.imm);
        check_field("imm_disp_len", e.imm_disp_len, sig.imm_disp_len);
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_x86_opnd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module tb_x86_opnd_decode import x86_opnd_pkg::*; ();

  localparam int NUM_ROWS = 16;

  // Stimulus row with its hand-worked expected result
  typedef struct packed {
    instr_window_t win;
    opnd_form_t    form;
    logic [3:0]    flags;
    opnd_sig_t     exp;
  } row_t;

  logic          clk;
  logic          arst_n;
  logic          in_valid;
  instr_window_t instr;
  opnd_form_t    form;
  logic          addr16;
  logic          oper16;
  logic          imm_1byte;
  logic          source_is_sext;
  logic          out_valid;
  opnd_sig_t     sig;
  row_t          rows [NUM_ROWS];
  int            row_count;
  logic [31:0]   lfsr;
  int            total_errors;

  x86_opnd_decode dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .instr          (instr),
    .form           (form),
    .addr16         (addr16),
    .oper16         (oper16),
    .imm_1byte      (imm_1byte),
    .source_is_sext (source_is_sext),
    .out_valid      (out_valid),
    .sig            (sig)
  );

  opnd_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .out_valid (out_valid),
    .sig       (sig)
  );

  bind x86_opnd_decode x86_opnd_decode_props u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .sig       (sig)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // flags is {addr16, oper16, imm_1byte, source_is_sext}
  // aflags is {has_modrm, has_sib, has_disp, is_disp8, is_disp32, rm_reg_direct,
  //   opnd0_rm, opnd0_reg, opnd1_rm, opnd1_reg, opnd0_disp, opnd1_disp}
  task automatic add_row(input instr_window_t win, input opnd_form_t form_code,
                         input logic [3:0] flags, input logic [11:0] aflags,
                         input byte_t modrm, input byte_t sib, input word32_t disp,
                         input logic has_imm, input word32_t imm, input total_len_t len);
    row_t r;
    r.win   = win;
    r.form  = form_code;
    r.flags = flags;
    // Struct order, presence flags then bytes, displacement, routing, immediate part
    r.exp = {aflags[11:6], modrm, sib, disp, aflags[5:0], has_imm, imm, len};
    rows[row_count] = r;
    row_count++;
  endtask

  // Called on a falling edge, strobes for one cycle
  task automatic apply_row(input row_t r);
    instr    = r.win;
    form     = r.form;
    {addr16, oper16, imm_1byte, source_is_sext} = r.flags;
    in_valid = 1'b1;
    u_checker.push_expected(r.exp);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  initial begin : main
    int idle;
    clk            = 1'b0;
    arst_n         = 1'b0;
    in_valid       = 1'b0;
    instr          = '0;
    form           = FORM_NONE;
    addr16         = 1'b0;
    oper16         = 1'b0;
    imm_1byte      = 1'b0;
    source_is_sext = 1'b0;
    lfsr           = 32'h6358;
    row_count      = 0;
    // Register-direct, SIB forms, addr16 suppressing SIB
    add_row(88'h77_66_55_c1, FORM_RM_REG, 4'b0000, 12'b100001_1001_00,
            8'hc1, 8'h00, 32'h0, 1'b0, 32'h0, 4'd0);
    add_row(88'h99_12_34_56_78_25_04, FORM_RM, 4'b0000, 12'b111010_1000_10,
            8'h04, 8'h25, 32'h12345678, 1'b0, 32'h0, 4'd4);
    add_row(88'h55_80_0b_44, FORM_RM_CL, 4'b0000, 12'b111100_1000_10,
            8'h44, 8'h0b, 32'hffffff80, 1'b0, 32'h0, 4'd1);
    add_row(88'h25_04, FORM_RM, 4'b1000, 12'b100000_1000_00,
            8'h04, 8'h00, 32'h0, 1'b0, 32'h0, 4'd0);
    // Immediates behind the addressing bytes
    add_row(88'hee_dd_cc_bb_aa_44_33_22_11_80, FORM_RM_IMM, 4'b0000, 12'b101010_1000_10,
            8'h80, 8'h00, 32'h44332211, 1'b1, 32'hddccbbaa, 4'd8);
    add_row(88'h33_f0_10_4b, FORM_REG_RM_IMM, 4'b0011, 12'b101100_0110_01,
            8'h4b, 8'h00, 32'h10, 1'b1, 32'hfffffff0, 4'd2);
    // Immediate size selection
    add_row(88'h99_f2_34, FORM_IMM, 4'b0100, 12'b000000_0000_00,
            8'h00, 8'h00, 32'h0, 1'b1, 32'h0000f234, 4'd2);
    add_row(88'h55_87_65_43_21, FORM_IMM, 4'b0000, 12'b000000_0000_00,
            8'h00, 8'h00, 32'h0, 1'b1, 32'h87654321, 4'd4);
    // Displacement-only forms
    add_row(88'h12_9c, FORM_DISP8, 4'b0000, 12'b001100_0000_10,
            8'h00, 8'h00, 32'h0000009c, 1'b0, 32'h0, 4'd1);
    add_row(88'h77_de_ad_be_ef, FORM_DISP32, 4'b0000, 12'b001010_0000_10,
            8'h00, 8'h00, 32'hdeadbeef, 1'b0, 32'h0, 4'd4);
    add_row(88'h9c, FORM_DISP8, 4'b0001, 12'b001100_0000_10,
            8'h00, 8'h00, 32'hffffff9c, 1'b0, 32'h0, 4'd1);
    add_row(88'h66_f5, FORM_REG_IMM, 4'b0010, 12'b000000_0000_00,
            8'h00, 8'h00, 32'h0, 1'b1, 32'h000000f5, 4'd1);
    add_row(88'hff_80_04_03_02_01_0d, FORM_RM_REG_IMM, 4'b0100, 12'b101010_1001_10,
            8'h0d, 8'h00, 32'h04030201, 1'b1, 32'h0000ff80, 4'd6);
    add_row(88'h80, FORM_EAX_IMM, 4'b0011, 12'b000000_0000_00,
            8'h00, 8'h00, 32'h0, 1'b1, 32'hffffff80, 4'd1);
    add_row(88'h89_ab_cd_ef_8d_0c, FORM_REG_RM, 4'b0000, 12'b111010_0110_01,
            8'h0c, 8'h8d, 32'h89abcdef, 1'b0, 32'h0, 4'd4);
    // Unused code 14 decodes as no operands
    add_row(88'h11_22_33, 4'd14, 4'b0000, 12'b000000_0000_00,
            8'h00, 8'h00, 32'h0, 1'b0, 32'h0, 4'd0);
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
      // Two LFSR bits give 0 to 3 idle cycles
      idle = 0;
      repeat (2) begin
        lfsr = lfsr_step(lfsr);
        idle = idle * 2 + lfsr[0];
      end
      repeat (idle) @(negedge clk);
    end
    // Drain, then leave room for stray beats
    while (u_checker.pending > 0) @(negedge clk);
    repeat (4) @(negedge clk);
    total_errors = u_checker.mismatches + u_checker.other_errors + dut.u_props.fail_count;
    $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
             u_checker.mismatches, u_checker.other_errors, dut.u_props.fail_count);
    if (total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Six cycles per row covers the worst-case gaps plus reset and drain
  initial begin : watchdog
    repeat (NUM_ROWS * 6 + 20) @(posedge clk);
    $display("Timeout after %0d cycles with %0d expected beats never seen",
             NUM_ROWS * 6 + 20, u_checker.pending);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- x86_opnd_decode.f
src/x86_opnd_pkg.sv
src/modrm_sib_decode.sv
src/imm_decode.sv
src/opnd_assemble.sv
src/x86_opnd_decode.sv
tests/x86_opnd_decode_props.sv
tests/opnd_checker.sv
tests/tb_x86_opnd_decode.sv
